//--- bench/cvxif_chk.sv
/*
 * Concurrent assertions on the coprocessor issue and result handshakes
 */

`timescale 1ns/1ps
`default_nettype none

`include "cvxif_macros.svh"

module cvxif_chk (
  input logic                 clk_i,
  input logic                 reset_i,
  input cvxif_pkg::instr_t    issue_instr_i,
  input logic                 issue_accept_o,
  input logic                 result_valid_o,
  input logic                 result_ready_i,
  input cvxif_pkg::xid_t      result_id_o,
  input cvxif_pkg::xlen_t     result_data_o,
  input cvxif_pkg::reg_addr_t result_rd_o,
  input logic                 result_we_o
);

  // Stalled result keeps every field
  result_stable_a: assert property (@(posedge clk_i) disable iff (reset_i)
    (result_valid_o && !result_ready_i) |=>
      (result_valid_o && $stable(result_id_o) && $stable(result_data_o) &&
       $stable(result_rd_o) && $stable(result_we_o)))
    else $error("result fields changed while stalled");

  accept_opcode_a: assert property (@(posedge clk_i) disable iff (reset_i)
    issue_accept_o |-> (issue_instr_i[6:0] == `CVXIF_OPCODE))
    else $error("issue_accept_o high for a foreign opcode");

  reset_idle_a: assert property (@(posedge clk_i) reset_i |=> !result_valid_o)
    else $error("result_valid_o high right after reset");

endmodule

bind cvxif_coprocessor cvxif_chk u_chk (
  .clk_i          (clk_i),
  .reset_i        (reset_i),
  .issue_instr_i  (issue_instr_i),
  .issue_accept_o (issue_accept_o),
  .result_valid_o (result_valid_o),
  .result_ready_i (result_ready_i),
  .result_id_o    (result_id_o),
  .result_data_o  (result_data_o),
  .result_rd_o    (result_rd_o),
  .result_we_o    (result_we_o)
);

`default_nettype wire

//--- bench/cvxif_tb.sv
/*
 * Directed testbench for the coprocessor with an in-order scoreboard
 */

`timescale 1ns/1ps
`default_nettype none

`include "cvxif_macros.svh"

module cvxif_tb;

  import cvxif_pkg::*;

  localparam int         TIMEOUT = 100;
  localparam logic [6:0] OPC     = `CVXIF_OPCODE;

  logic      clk_i;
  logic      reset_i;
  logic      issue_valid_i;
  logic      issue_ready_o;
  instr_t    issue_instr_i;
  xid_t      issue_id_i;
  xlen_t     issue_rs1_i;
  xlen_t     issue_rs2_i;
  xlen_t     issue_rs3_i;
  rs_valid_t issue_rs_valid_i;
  logic      issue_accept_o;
  logic      issue_writeback_o;
  logic      commit_valid_i;
  logic      commit_kill_i;
  xid_t      commit_id_i;
  logic      result_valid_o;
  logic      result_ready_i;
  xid_t      result_id_o;
  xlen_t     result_data_o;
  reg_addr_t result_rd_o;
  logic      result_we_o;

  integer seed = 32'h3252;
  int     error_count = 0;
  int     check_count = 0;

  // Expected results, oldest first
  xid_t      exp_id_q[$];
  xlen_t     exp_data_q[$];
  reg_addr_t exp_rd_q[$];
  logic      exp_we_q[$];

  cvxif_coprocessor dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  task automatic check_value(input string test, input string field,
                             input logic [31:0] expected, input logic [31:0] actual);
    check_count++;
    if (expected !== actual) begin
      error_count++;
      $display("FAILED %s %s: expected %h, actual %h", test, field, expected, actual);
    end
  endtask

  // Accept rule: own opcode, funct3 0..2, needed operands valid
  function automatic logic predict_accept(input logic [6:0] opcode, input logic [2:0] funct3,
                                          input rs_valid_t rs_valid);
    logic need_rs3;
    need_rs3 = (funct3 == 3'd1);
    if (opcode != OPC || funct3 > 3'd2) begin
      return 1'b0;
    end
    return rs_valid[0] && rs_valid[1] && (!need_rs3 || rs_valid[2]);
  endfunction

  task automatic issue_instr(input string test, input logic [6:0] opcode,
                             input logic [2:0] funct3, input xid_t id,
                             input reg_addr_t rd, input rs_valid_t rs_valid);
    xlen_t rs1;
    xlen_t rs2;
    xlen_t rs3;
    logic  exp_accept;
    logic  handshake;
    int    waited;
    rs1 = $random(seed);
    rs2 = $random(seed);
    rs3 = $random(seed);
    exp_accept = predict_accept(opcode, funct3, rs_valid);
    @(posedge clk_i);
    issue_valid_i    <= 1'b1;
    issue_instr_i    <= {5'd3, 2'b00, 5'd2, 5'd1, funct3, rd, opcode};
    issue_id_i       <= id;
    issue_rs1_i      <= rs1;
    issue_rs2_i      <= rs2;
    issue_rs3_i      <= rs3;
    issue_rs_valid_i <= rs_valid;
    @(negedge clk_i);
    check_value(test, "accept", exp_accept, issue_accept_o);
    check_value(test, "writeback", exp_accept && (funct3 != 3'd2), issue_writeback_o);
    waited = 0;
    while (!issue_ready_o && waited < TIMEOUT) begin
      @(negedge clk_i);
      waited++;
    end
    handshake = issue_ready_o;
    if (!handshake) begin
      error_count++;
      $display("ERROR: %s timed out waiting for issue_ready_o", test);
    end
    @(posedge clk_i);
    issue_valid_i <= 1'b0;
    if (exp_accept && handshake) begin
      exp_id_q.push_back(id);
      exp_data_q.push_back(rs1 + rs2 + ((funct3 == 3'd1) ? rs3 : '0));
      exp_rd_q.push_back(rd);
      exp_we_q.push_back(funct3 != 3'd2);
    end
  endtask

  task automatic commit_instr(input xid_t id, input logic kill);
    int idx;
    @(posedge clk_i);
    commit_valid_i <= 1'b1;
    commit_id_i    <= id;
    commit_kill_i  <= kill;
    @(posedge clk_i);
    commit_valid_i <= 1'b0;
    commit_kill_i  <= 1'b0;
    if (kill) begin
      idx = -1;
      for (int i = 0; i < exp_id_q.size(); i++) begin
        if (exp_id_q[i] == id) begin
          idx = i;
        end
      end
      if (idx >= 0) begin
        exp_id_q.delete(idx);
        exp_data_q.delete(idx);
        exp_rd_q.delete(idx);
        exp_we_q.delete(idx);
      end
    end
  endtask

  task automatic wait_result(input string test, output logic seen);
    int waited;
    waited = 0;
    @(negedge clk_i);
    while (!result_valid_o && waited < TIMEOUT) begin
      @(negedge clk_i);
      waited++;
    end
    seen = result_valid_o;
    if (!seen) begin
      error_count++;
      $display("ERROR: %s saw no result within %0d cycles", test, TIMEOUT);
    end
  endtask

  task automatic expect_result(input string test);
    logic seen;
    wait_result(test, seen);
    if (!seen) begin
      return;
    end
    if (exp_id_q.size() == 0) begin
      error_count++;
      $display("ERROR: %s returned a result nobody expected", test);
    end else begin
      check_value(test, "id", exp_id_q.pop_front(), result_id_o);
      check_value(test, "data", exp_data_q.pop_front(), result_data_o);
      check_value(test, "rd", exp_rd_q.pop_front(), result_rd_o);
      check_value(test, "we", exp_we_q.pop_front(), result_we_o);
    end
    // One cycle of ready completes the handshake
    @(posedge clk_i);
    result_ready_i <= 1'b1;
    @(posedge clk_i);
    result_ready_i <= 1'b0;
  endtask

  task automatic check_idle(input string test, input int cycles);
    repeat (cycles) begin
      @(negedge clk_i);
      check_value(test, "result_valid", 1'b0, result_valid_o);
    end
  endtask

  task automatic test_reject();
    issue_instr("reject_opcode", 7'h33, 3'd0, 4'd1, 5'd4, 3'b111);
    issue_instr("reject_funct3", OPC, 3'd3, 4'd2, 5'd4, 3'b111);
    issue_instr("reject_rs3", OPC, 3'd1, 4'd3, 5'd4, 3'b011);
    // Rejected ids are committed as well and still return nothing
    commit_instr(4'd1, 1'b0);
    commit_instr(4'd2, 1'b0);
    commit_instr(4'd3, 1'b0);
    check_idle("reject", 40);
  endtask

  task automatic test_add_forms();
    issue_instr("add2", OPC, 3'd0, 4'd1, 5'd7, 3'b011);
    commit_instr(4'd1, 1'b0);
    expect_result("add2");
    issue_instr("add3", OPC, 3'd1, 4'd2, 5'd19, 3'b111);
    commit_instr(4'd2, 1'b0);
    expect_result("add3");
    issue_instr("add_nowb", OPC, 3'd2, 4'd3, 5'd25, 3'b111);
    commit_instr(4'd3, 1'b0);
    expect_result("add_nowb");
  endtask

  task automatic test_kill();
    issue_instr("kill", OPC, 3'd0, 4'd4, 5'd8, 3'b011);
    issue_instr("kill", OPC, 3'd1, 4'd5, 5'd9, 3'b111);
    commit_instr(4'd4, 1'b1);
    commit_instr(4'd5, 1'b0);
    expect_result("kill");
    check_idle("kill", 20);
  endtask

  task automatic test_backpressure();
    xlen_t held_data;
    xid_t  held_id;
    logic  seen;
    issue_instr("stall", OPC, 3'd0, 4'd9, 5'd12, 3'b011);
    commit_instr(4'd9, 1'b0);
    wait_result("stall", seen);
    if (seen) begin
      held_data = result_data_o;
      held_id   = result_id_o;
      repeat (20) begin
        @(negedge clk_i);
        check_value("stall", "valid", 1'b1, result_valid_o);
        check_value("stall", "data", held_data, result_data_o);
        check_value("stall", "id", held_id, result_id_o);
      end
    end
    expect_result("stall");
    // Fill every slot with uncommitted work
    for (int i = 0; i < `CVXIF_QUEUE_DEPTH; i++) begin
      issue_instr("full", OPC, 3'd0, xid_t'(i + 10), reg_addr_t'(i + 1), 3'b011);
    end
    @(negedge clk_i);
    check_value("full", "issue_ready", 1'b0, issue_ready_o);
    for (int i = 0; i < `CVXIF_QUEUE_DEPTH; i++) begin
      commit_instr(xid_t'(i + 10), 1'b0);
    end
    for (int i = 0; i < `CVXIF_QUEUE_DEPTH; i++) begin
      expect_result("full");
    end
    @(negedge clk_i);
    check_value("full", "issue_ready", 1'b1, issue_ready_o);
  endtask

  task automatic test_ordering();
    issue_instr("order", OPC, 3'd0, 4'd5, 5'd1, 3'b011);
    issue_instr("order", OPC, 3'd1, 4'd6, 5'd2, 3'b111);
    issue_instr("order", OPC, 3'd2, 4'd7, 5'd3, 3'b111);
    commit_instr(4'd7, 1'b0);
    commit_instr(4'd5, 1'b0);
    commit_instr(4'd6, 1'b0);
    repeat (3) begin
      expect_result("order");
    end
  endtask

  initial begin
    reset_i          <= 1'b1;
    issue_valid_i    <= 1'b0;
    issue_instr_i    <= '0;
    issue_id_i       <= '0;
    issue_rs1_i      <= '0;
    issue_rs2_i      <= '0;
    issue_rs3_i      <= '0;
    issue_rs_valid_i <= '0;
    commit_valid_i   <= 1'b0;
    commit_kill_i    <= 1'b0;
    commit_id_i      <= '0;
    result_ready_i   <= 1'b0;
    repeat (3) @(posedge clk_i);
    reset_i <= 1'b0;
    @(negedge clk_i);
    check_value("reset", "issue_ready", 1'b1, issue_ready_o);
    check_value("reset", "result_valid", 1'b0, result_valid_o);
    test_reject();
    test_add_forms();
    test_kill();
    test_backpressure();
    test_ordering();
    check_value("final", "pending results", 0, exp_id_q.size());
    $display("Checks run: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
+incdir+hdl
hdl/cvxif_pkg.sv
hdl/cvxif_instr_decoder.sv
hdl/cvxif_issue_queue.sv
hdl/cvxif_result_unit.sv
hdl/cvxif_coprocessor.sv
bench/cvxif_chk.sv
bench/cvxif_tb.sv

//--- hdl/cvxif_coprocessor.sv
/*
 * Example coprocessor top: decoder, issue queue and result unit
 */

`timescale 1ns/1ps
`default_nettype none

`include "cvxif_macros.svh"

module cvxif_coprocessor (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 issue_valid_i,
  output logic                 issue_ready_o,
  input  cvxif_pkg::instr_t    issue_instr_i,
  input  cvxif_pkg::xid_t      issue_id_i,
  input  cvxif_pkg::xlen_t     issue_rs1_i,
  input  cvxif_pkg::xlen_t     issue_rs2_i,
  input  cvxif_pkg::xlen_t     issue_rs3_i,
  input  cvxif_pkg::rs_valid_t issue_rs_valid_i,
  output logic                 issue_accept_o,
  output logic                 issue_writeback_o,
  input  logic                 commit_valid_i,
  input  logic                 commit_kill_i,
  input  cvxif_pkg::xid_t      commit_id_i,
  output logic                 result_valid_o,
  input  logic                 result_ready_i,
  output cvxif_pkg::xid_t      result_id_o,
  output cvxif_pkg::xlen_t     result_data_o,
  output cvxif_pkg::reg_addr_t result_rd_o,
  output logic                 result_we_o
);

  import cvxif_pkg::*;

  logic      decode_accept;
  logic      decode_writeback;
  logic      decode_use_rs3;
  logic      issue_ready;
  logic      push;
  xlen_t     push_rs3;
  logic      head_valid;
  logic      head_committed;
  xid_t      head_id;
  reg_addr_t head_rd;
  logic      head_writeback;
  xlen_t     head_rs1;
  xlen_t     head_rs2;
  xlen_t     head_rs3;
  logic      head_pop;

  cvxif_instr_decoder u_decoder (
    .issue_instr_i      (issue_instr_i),
    .issue_rs_valid_i   (issue_rs_valid_i),
    .decode_accept_o    (decode_accept),
    .decode_writeback_o (decode_writeback),
    .decode_use_rs3_o   (decode_use_rs3)
  );

  assign issue_ready_o     = issue_ready;
  assign issue_accept_o    = decode_accept;
  assign issue_writeback_o = decode_writeback;

  // Only accepted instructions of a completed handshake enter the queue
  assign push     = issue_valid_i & issue_ready & decode_accept;
  assign push_rs3 = decode_use_rs3 ? issue_rs3_i : '0;

  cvxif_issue_queue #(
    .DEPTH (`CVXIF_QUEUE_DEPTH)
  ) u_queue (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .push_i           (push),
    .push_id_i        (issue_id_i),
    .push_rd_i        (issue_instr_i[11:7]),
    .push_writeback_i (decode_writeback),
    .push_rs1_i       (issue_rs1_i),
    .push_rs2_i       (issue_rs2_i),
    .push_rs3_i       (push_rs3),
    .commit_valid_i   (commit_valid_i),
    .commit_kill_i    (commit_kill_i),
    .commit_id_i      (commit_id_i),
    .head_pop_i       (head_pop),
    .issue_ready_o    (issue_ready),
    .head_valid_o     (head_valid),
    .head_committed_o (head_committed),
    .head_id_o        (head_id),
    .head_rd_o        (head_rd),
    .head_writeback_o (head_writeback),
    .head_rs1_o       (head_rs1),
    .head_rs2_o       (head_rs2),
    .head_rs3_o       (head_rs3)
  );

  cvxif_result_unit u_result (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .head_valid_i     (head_valid),
    .head_committed_i (head_committed),
    .head_id_i        (head_id),
    .head_rd_i        (head_rd),
    .head_writeback_i (head_writeback),
    .head_rs1_i       (head_rs1),
    .head_rs2_i       (head_rs2),
    .head_rs3_i       (head_rs3),
    .result_ready_i   (result_ready_i),
    .head_pop_o       (head_pop),
    .result_valid_o   (result_valid_o),
    .result_we_o      (result_we_o),
    .result_id_o      (result_id_o),
    .result_data_o    (result_data_o),
    .result_rd_o      (result_rd_o)
  );

endmodule

`default_nettype wire

//--- hdl/cvxif_instr_decoder.sv
/*
 * Decode of the custom add instructions into accept, writeback
 * and rs3 usage for the offered request
 */

`timescale 1ns/1ps
`default_nettype none

`include "cvxif_macros.svh"

module cvxif_instr_decoder (
  input  cvxif_pkg::instr_t    issue_instr_i,
  input  cvxif_pkg::rs_valid_t issue_rs_valid_i,
  output logic                 decode_accept_o,
  output logic                 decode_writeback_o,
  output logic                 decode_use_rs3_o
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic       opcode_hit;
  logic       known_instr;
  logic       wants_writeback;
  logic       needs_rs3;
  logic       operands_ok;

  assign opcode = issue_instr_i[6:0];
  assign funct3 = issue_instr_i[14:12];

  assign opcode_hit = (opcode == `CVXIF_OPCODE);

  // Instruction table, indexed by funct3
  always_comb begin
    known_instr     = 1'b0;
    wants_writeback = 1'b0;
    needs_rs3       = 1'b0;
    case (funct3)
      3'd0: begin
        // rd = rs1 + rs2
        known_instr     = 1'b1;
        wants_writeback = 1'b1;
      end
      3'd1: begin
        // rd = rs1 + rs2 + rs3, rs3 in bits 31:27
        known_instr     = 1'b1;
        wants_writeback = 1'b1;
        needs_rs3       = 1'b1;
      end
      3'd2: begin
        // Sum is computed but not written back
        known_instr     = 1'b1;
      end
      default: begin
        known_instr     = 1'b0;
      end
    endcase
  end

  // rs1 and rs2 always needed, rs3 only for the three-source form
  assign operands_ok = issue_rs_valid_i[0] & issue_rs_valid_i[1] &
                       (~needs_rs3 | issue_rs_valid_i[2]);

  assign decode_accept_o    = opcode_hit & known_instr & operands_ok;
  assign decode_writeback_o = decode_accept_o & wants_writeback;
  assign decode_use_rs3_o   = opcode_hit & needs_rs3;

endmodule

`default_nettype wire

//--- hdl/cvxif_issue_queue.sv
/*
 * In-order issue queue with per-slot commit and kill flags,
 * automatic drop of killed heads and a registered issue ready
 */

`timescale 1ns/1ps
`default_nettype none

`include "cvxif_macros.svh"

module cvxif_issue_queue #(
  parameter int DEPTH = `CVXIF_QUEUE_DEPTH
) (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 push_i,
  input  cvxif_pkg::xid_t      push_id_i,
  input  cvxif_pkg::reg_addr_t push_rd_i,
  input  logic                 push_writeback_i,
  input  cvxif_pkg::xlen_t     push_rs1_i,
  input  cvxif_pkg::xlen_t     push_rs2_i,
  input  cvxif_pkg::xlen_t     push_rs3_i,
  input  logic                 commit_valid_i,
  input  logic                 commit_kill_i,
  input  cvxif_pkg::xid_t      commit_id_i,
  input  logic                 head_pop_i,
  output logic                 issue_ready_o,
  output logic                 head_valid_o,
  output logic                 head_committed_o,
  output cvxif_pkg::xid_t      head_id_o,
  output cvxif_pkg::reg_addr_t head_rd_o,
  output logic                 head_writeback_o,
  output cvxif_pkg::xlen_t     head_rs1_o,
  output cvxif_pkg::xlen_t     head_rs2_o,
  output cvxif_pkg::xlen_t     head_rs3_o
);

  import cvxif_pkg::*;

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W-1:0] wr_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic [CNT_W-1:0] count_next;

  // Per-slot control flags
  logic [DEPTH-1:0] slot_valid_q;
  logic [DEPTH-1:0] slot_committed_q;
  logic [DEPTH-1:0] slot_killed_q;

  // Per-slot payload
  xid_t             slot_id_q  [DEPTH];
  reg_addr_t        slot_rd_q  [DEPTH];
  logic [DEPTH-1:0] slot_wb_q;
  xlen_t            slot_rs1_q [DEPTH];
  xlen_t            slot_rs2_q [DEPTH];
  xlen_t            slot_rs3_q [DEPTH];

  logic drop_killed;
  logic pop;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // A killed head leaves on its own, a committed one waits for the result unit
  assign drop_killed = slot_valid_q[rd_ptr_q] & slot_killed_q[rd_ptr_q];
  assign pop         = head_pop_i | drop_killed;

  always_comb begin
    count_next = count_q;
    if (push_i && !pop) begin
      count_next = count_q + 1'b1;
    end else if (pop && !push_i) begin
      count_next = count_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rd_ptr_q         <= '0;
      wr_ptr_q         <= '0;
      count_q          <= '0;
      slot_valid_q     <= '0;
      slot_committed_q <= '0;
      slot_killed_q    <= '0;
      issue_ready_o    <= 1'b1;
    end else begin
      // Commit marks every live slot holding the id
      for (int i = 0; i < DEPTH; i++) begin
        if (commit_valid_i && slot_valid_q[i] && (slot_id_q[i] == commit_id_i)) begin
          if (commit_kill_i) begin
            slot_killed_q[i] <= 1'b1;
          end else begin
            slot_committed_q[i] <= 1'b1;
          end
        end
      end
      if (pop) begin
        slot_valid_q[rd_ptr_q]     <= 1'b0;
        slot_committed_q[rd_ptr_q] <= 1'b0;
        slot_killed_q[rd_ptr_q]    <= 1'b0;
        rd_ptr_q                   <= ptr_inc(rd_ptr_q);
      end
      if (push_i) begin
        slot_valid_q[wr_ptr_q]     <= 1'b1;
        slot_committed_q[wr_ptr_q] <= 1'b0;
        slot_killed_q[wr_ptr_q]    <= 1'b0;
        wr_ptr_q                   <= ptr_inc(wr_ptr_q);
      end
      count_q <= count_next;
      // Ready only while a further push still fits
      issue_ready_o <= (count_next < CNT_W'(DEPTH));
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      slot_id_q[wr_ptr_q]  <= push_id_i;
      slot_rd_q[wr_ptr_q]  <= push_rd_i;
      slot_wb_q[wr_ptr_q]  <= push_writeback_i;
      slot_rs1_q[wr_ptr_q] <= push_rs1_i;
      slot_rs2_q[wr_ptr_q] <= push_rs2_i;
      slot_rs3_q[wr_ptr_q] <= push_rs3_i;
    end
  end

  // Killed heads are hidden from the result unit
  assign head_valid_o     = slot_valid_q[rd_ptr_q] & ~slot_killed_q[rd_ptr_q];
  assign head_committed_o = slot_committed_q[rd_ptr_q];
  assign head_id_o        = slot_id_q[rd_ptr_q];
  assign head_rd_o        = slot_rd_q[rd_ptr_q];
  assign head_writeback_o = slot_wb_q[rd_ptr_q];
  assign head_rs1_o       = slot_rs1_q[rd_ptr_q];
  assign head_rs2_o       = slot_rs2_q[rd_ptr_q];
  assign head_rs3_o       = slot_rs3_q[rd_ptr_q];

endmodule

`default_nettype wire

//--- hdl/cvxif_macros.svh
/*
 * Width, depth and opcode parameters for the CV-X-IF example coprocessor
 */

`ifndef CVXIF_MACROS_SVH
`define CVXIF_MACROS_SVH

// Operand and result width
`define CVXIF_XLEN 32

// Instruction id width on issue, commit and result
`define CVXIF_ID_WIDTH 4

// Source operands offered by the core (rs1, rs2, rs3)
`define CVXIF_NUM_RS 3

// Issue queue slots
`define CVXIF_QUEUE_DEPTH 4

// Major opcode shared by all three custom instructions
`define CVXIF_OPCODE 7'h7B

`endif

//--- hdl/cvxif_pkg.sv
/*
 * Data types shared by the coprocessor modules
 */

`default_nettype none

`include "cvxif_macros.svh"

package cvxif_pkg;

  // Operand and result data
  typedef logic [`CVXIF_XLEN-1:0] xlen_t;

  // Instruction id as seen on issue, commit and result
  typedef logic [`CVXIF_ID_WIDTH-1:0] xid_t;

  // Uncompressed instruction word
  typedef logic [31:0] instr_t;

  // Integer register address
  typedef logic [4:0] reg_addr_t;

  // One valid bit per offered source operand
  typedef logic [`CVXIF_NUM_RS-1:0] rs_valid_t;

  // Result unit states
  typedef enum logic [1:0] {
    RES_IDLE  = 2'd0,
    RES_DELAY = 2'd1,
    RES_SEND  = 2'd2
  } res_state_t;

endpackage

`default_nettype wire

//--- hdl/cvxif_result_unit.sv
/*
 * Operand sum, data-dependent delay and the result valid/ready
 * handshake with head pop
 */

`timescale 1ns/1ps
`default_nettype none

module cvxif_result_unit (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 head_valid_i,
  input  logic                 head_committed_i,
  input  cvxif_pkg::xid_t      head_id_i,
  input  cvxif_pkg::reg_addr_t head_rd_i,
  input  logic                 head_writeback_i,
  input  cvxif_pkg::xlen_t     head_rs1_i,
  input  cvxif_pkg::xlen_t     head_rs2_i,
  input  cvxif_pkg::xlen_t     head_rs3_i,
  input  logic                 result_ready_i,
  output logic                 head_pop_o,
  output logic                 result_valid_o,
  output logic                 result_we_o,
  output cvxif_pkg::xid_t      result_id_o,
  output cvxif_pkg::xlen_t     result_data_o,
  output cvxif_pkg::reg_addr_t result_rd_o
);

  import cvxif_pkg::*;

  res_state_t state_q;
  res_state_t state_d;
  logic [3:0] delay_cnt_q;
  logic       delay_done;
  xlen_t      sum;

  // rs3 arrives as zero for the two-source forms
  assign sum = head_rs1_i + head_rs2_i + head_rs3_i;

  // Delay length taken from the result itself
  assign delay_done = (delay_cnt_q == sum[3:0]);

  always_comb begin
    state_d = state_q;
    case (state_q)
      RES_IDLE: begin
        if (head_valid_i && head_committed_i) begin
          state_d = RES_DELAY;
        end
      end
      RES_DELAY: begin
        if (delay_done) begin
          state_d = RES_SEND;
        end
      end
      RES_SEND: begin
        if (result_ready_i) begin
          state_d = RES_IDLE;
        end
      end
      default: begin
        state_d = RES_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q     <= RES_IDLE;
      delay_cnt_q <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == RES_IDLE) begin
        delay_cnt_q <= '0;
      end else if (state_q == RES_DELAY && !delay_done) begin
        delay_cnt_q <= delay_cnt_q + 1'b1;
      end
    end
  end

  assign result_valid_o = (state_q == RES_SEND);
  assign head_pop_o     = result_valid_o & result_ready_i;

  // Head stays put until popped, so the fields hold under back-pressure
  assign result_id_o   = head_id_i;
  assign result_data_o = sum;
  assign result_rd_o   = head_rd_i;
  assign result_we_o   = head_writeback_i & result_valid_o;

endmodule

`default_nettype wire
